/* prod_buf.f */
+incdir+tb
hw/prod_buf_pkg.sv
hw/mult_lane.sv
hw/mem_arbiter.sv
hw/product_ram.sv
hw/prod_buf_top.sv
tb/prod_buf_tb.sv

/* Bender.yml */
package:
  name: prod_buf

sources:
  - target: any(rtl, test)
    files:
      - hw/prod_buf_pkg.sv
      - hw/mult_lane.sv
      - hw/mem_arbiter.sv
      - hw/product_ram.sv
      - hw/prod_buf_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/prod_buf_tb.sv

/* tb/prod_buf_checks.svh */
`ifndef PROD_BUF_CHECKS_SVH
`define PROD_BUF_CHECKS_SVH

// error counters, summed up in the closing line
int mismatch_errs = 0;
int other_errs = 0;

// one lfsr state per lane
logic [31:0] lfsr_state [2];

// fibonacci taps 32 22 2 1, one step per bit taken
function automatic logic [31:0] lfsr_bits(input int lane, input int n);
    logic [31:0] r;
    logic [31:0] s;
    r = '0;
    s = lfsr_state[lane];
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], s[31]};
        s = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    end
    lfsr_state[lane] = s;
    return r;
endfunction

// one product word against the model
task automatic check_product(input string name, input product_t got,
                             input product_t exp_val);
    if (got !== exp_val) begin
        mismatch_errs++;
        $display("MISMATCH %s got 0x%08h expected 0x%08h at %0t", name, got, exp_val, $time);
    end
endtask

// single level such as mult_rdy or block_full
task automatic check_flag(input string name, input logic got, input logic exp_val);
    if (got !== exp_val) begin
        mismatch_errs++;
        $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp_val, $time);
    end
endtask

// anything that is not a wrong value
task automatic report_error(input string msg);
    other_errs++;
    $display("ERROR %s at %0t", msg, $time);
endtask

`endif

/* tb/prod_buf_tb.sv */
`default_nettype none

// testbench for the two-lane product buffer
module prod_buf_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import prod_buf_pkg::*;

    localparam int LOGDEPTH       = 6;
    localparam int BLOCK_WORDS    = 2 ** LOGDEPTH;
    localparam int NUM_CASES      = 6;
    // four block passes of 128 cycles per case, plus reset and slack
    localparam int TIMEOUT_CYCLES = NUM_CASES * 4 * 128 + 200;

    // one row of the case table
    typedef struct packed {
        logic [1:0] fill;      // lanes that fill
        logic       edge_ops;  // fixed edge operands instead of lfsr
        logic [1:0] gap;       // idle enables, in quarters
        logic       first;     // lane read first
        logic       overlap;   // first lane drains while the other fills
    } case_t;

    logic        clk = 1'b0;
    logic        rst;
    logic [1:0]  mult_en;
    operand_t    op_a [2];
    operand_t    op_b [2];
    logic [1:0]  mult_rdy;
    logic [1:0]  block_read;
    logic [1:0]  rd_valid;
    product_t    rd_data [2];
    logic [1:0]  block_full;

    case_t       case_tbl [NUM_CASES];
    // reference model, expected products per lane in order
    product_t    exp_q0 [$];
    product_t    exp_q1 [$];
    int          acc_count [2];
    int          rd_count [2];
    int          cycle_cnt;
    lane_state_t dbg_state0;
    lane_state_t dbg_state1;

    `include "prod_buf_checks.svh"

    always #5 clk = ~clk;

    prod_buf_top #(
        .LOGDEPTH (LOGDEPTH)
    ) prod_buf_top_inst (
        .clk        (clk),
        .rst        (rst),
        .mult_en    (mult_en),
        .op_a       (op_a),
        .op_b       (op_b),
        .mult_rdy   (mult_rdy),
        .block_read (block_read),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .block_full (block_full)
    );

    // pop the oldest product of a lane and compare
    task automatic match_read(input int lane);
        product_t exp_word;
        int       left;
        left = (lane == 0) ? exp_q0.size() : exp_q1.size();
        rd_count[lane]++;
        if (left == 0) begin
            report_error($sformatf("lane %0d returned a word with no product pending", lane));
        end else begin
            if (lane == 0) begin
                exp_word = exp_q0.pop_front();
            end else begin
                exp_word = exp_q1.pop_front();
            end
            check_product($sformatf("rd_data[%0d]", lane), rd_data[lane], exp_word);
        end
    endtask

    // inputs settled half a cycle ago, registers not yet updated
    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2; i++) begin
                if (mult_en[i] && mult_rdy[i]) begin
                    if (i == 0) begin
                        exp_q0.push_back({16'h0000, op_a[i]} * {16'h0000, op_b[i]});
                    end else begin
                        exp_q1.push_back({16'h0000, op_a[i]} * {16'h0000, op_b[i]});
                    end
                    acc_count[i]++;
                end
                if (rd_valid[i]) begin
                    match_read(i);
                end
            end
        end
    end

    // drive pairs until a whole block is taken, then poke the full lane
    task automatic fill_block(input int lane, input case_t c);
        int target;
        target = acc_count[lane] + BLOCK_WORDS;
        while (acc_count[lane] < target) begin
            mult_en[lane] = (lfsr_bits(lane, 2) >= 32'(c.gap));
            op_a[lane] = operand_t'(lfsr_bits(lane, 16));
            op_b[lane] = operand_t'(lfsr_bits(lane, 16));
            // edge kind follows the accepted count, so each one lands
            if (c.edge_ops) begin
                case (acc_count[lane] % 4)
                    0: op_a[lane] = 16'h0000;
                    1: begin
                        op_a[lane] = 16'hffff;
                        op_b[lane] = 16'hffff;
                    end
                    2: op_a[lane] = 16'h0001;
                    default: op_b[lane] = 16'h0001;
                endcase
            end
            @(negedge clk);
        end
        mult_en[lane] = 1'b0;
        while (!block_full[lane]) begin
            @(negedge clk);
        end
        // enables while full are refused
        repeat (3) begin
            check_flag($sformatf("mult_rdy[%0d]", lane), mult_rdy[lane], 1'b0);
            check_flag($sformatf("block_full[%0d]", lane), block_full[lane], 1'b1);
            mult_en[lane] = 1'b1;
            @(negedge clk);
        end
        mult_en[lane] = 1'b0;
    endtask

    task automatic drain_block(input int lane);
        int target;
        target = rd_count[lane] + BLOCK_WORDS;
        block_read[lane] = 1'b1;
        @(negedge clk);
        block_read[lane] = 1'b0;
        while (rd_count[lane] < target) begin
            @(negedge clk);
        end
        // lane back in idle after the last word
        check_flag($sformatf("block_full[%0d]", lane), block_full[lane], 1'b0);
        check_flag($sformatf("mult_rdy[%0d]", lane), mult_rdy[lane], 1'b1);
    endtask

    task automatic run_case(input case_t c);
        int a;
        int b;
        a = c.first;
        b = 1 - a;
        // block_read on idle lanes, no word may come back
        block_read = 2'b11;
        @(negedge clk);
        block_read = 2'b00;
        repeat (3) @(negedge clk);
        if (c.fill == 2'b11 && c.overlap) begin
            fill_block(a, c);
            fork
                drain_block(a);
                fill_block(b, c);
            join
            drain_block(b);
        end else if (c.fill == 2'b11) begin
            fork
                fill_block(0, c);
                fill_block(1, c);
            join
            drain_block(a);
            drain_block(b);
        end else begin
            fill_block(c.fill[1], c);
            drain_block(c.fill[1]);
        end
        repeat (4) @(negedge clk);
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            report_error($sformatf("products never read back, lane 0 has %0d, lane 1 has %0d",
                                   exp_q0.size(), exp_q1.size()));
        end
    endtask

    initial begin
        rst = 1'b1;
        mult_en = 2'b00;
        block_read = 2'b00;
        op_a = '{16'h0000, 16'h0000};
        op_b = '{16'h0000, 16'h0000};
        acc_count = '{0, 0};
        rd_count = '{0, 0};
        lfsr_state[0] = 32'h6a6c;
        lfsr_state[1] = 32'h6a6c;
        // lane 1 runs 32 steps ahead so the lanes differ
        void'(lfsr_bits(1, 32));
        //             fill   edge  gap   first overlap
        case_tbl[0] = {2'b01, 1'b0, 2'd0, 1'b0, 1'b0};
        case_tbl[1] = {2'b10, 1'b0, 2'd2, 1'b1, 1'b0};
        case_tbl[2] = {2'b11, 1'b0, 2'd1, 1'b0, 1'b0};
        case_tbl[3] = {2'b11, 1'b0, 2'd1, 1'b1, 1'b1};
        case_tbl[4] = {2'b01, 1'b1, 2'd0, 1'b0, 1'b0};
        case_tbl[5] = {2'b11, 1'b1, 2'd3, 1'b0, 1'b1};
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < 2; i++) begin
            check_flag($sformatf("mult_rdy[%0d]", i), mult_rdy[i], 1'b1);
            check_flag($sformatf("rd_valid[%0d]", i), rd_valid[i], 1'b0);
            check_flag($sformatf("block_full[%0d]", i), block_full[i], 1'b0);
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            $display("case %0d at %0t", i, $time);
            run_case(case_tbl[i]);
        end
        $display("done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if (mismatch_errs + other_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // watchdog over the whole run
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        dbg_state0 = prod_buf_top_inst.lane0_inst.state;
        dbg_state1 = prod_buf_top_inst.lane1_inst.state;
        report_error($sformatf("run did not finish within %0d cycles, lanes in %s and %s",
                               cycle_cnt, dbg_state0.name(), dbg_state1.name()));
        $display("done: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/prod_buf_top.sv */
`default_nettype none

// two-lane product buffer
// two multiplier lanes share one memory through the arbiter
module prod_buf_top #(
    parameter int LOGDEPTH = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             mult_en,
    input  prod_buf_pkg::operand_t op_a [2],
    input  prod_buf_pkg::operand_t op_b [2],
    output logic [1:0]             mult_rdy,
    input  logic [1:0]             block_read,
    output logic [1:0]             rd_valid,
    output prod_buf_pkg::product_t rd_data [2],
    output logic [1:0]             block_full
);
    import prod_buf_pkg::*;

    // lane side of the memory port
    logic [1:0]          lane_req;
    logic [1:0]          lane_we;
    logic [LOGDEPTH-1:0] lane_addr [2];
    product_t            lane_wdata [2];
    logic [1:0]          lane_gnt;

    // arbiter to ram
    logic              ram_en;
    logic              ram_we;
    logic [LOGDEPTH:0] ram_addr;
    product_t          ram_wdata;
    // read data broadcast to both lanes
    product_t          ram_rdata;

    mult_lane #(
        .LOGDEPTH (LOGDEPTH)
    ) lane0_inst (
        .clk        (clk),
        .rst        (rst),
        .mult_en    (mult_en[0]),
        .op_a       (op_a[0]),
        .op_b       (op_b[0]),
        .mult_rdy   (mult_rdy[0]),
        .block_read (block_read[0]),
        .block_full (block_full[0]),
        .rd_valid   (rd_valid[0]),
        .rd_data    (rd_data[0]),
        .mem_req    (lane_req[0]),
        .mem_we     (lane_we[0]),
        .mem_addr   (lane_addr[0]),
        .mem_wdata  (lane_wdata[0]),
        .mem_gnt    (lane_gnt[0]),
        .mem_rdata  (ram_rdata)
    );

    mult_lane #(
        .LOGDEPTH (LOGDEPTH)
    ) lane1_inst (
        .clk        (clk),
        .rst        (rst),
        .mult_en    (mult_en[1]),
        .op_a       (op_a[1]),
        .op_b       (op_b[1]),
        .mult_rdy   (mult_rdy[1]),
        .block_read (block_read[1]),
        .block_full (block_full[1]),
        .rd_valid   (rd_valid[1]),
        .rd_data    (rd_data[1]),
        .mem_req    (lane_req[1]),
        .mem_we     (lane_we[1]),
        .mem_addr   (lane_addr[1]),
        .mem_wdata  (lane_wdata[1]),
        .mem_gnt    (lane_gnt[1]),
        .mem_rdata  (ram_rdata)
    );

    mem_arbiter #(
        .LOGDEPTH (LOGDEPTH)
    ) mem_arbiter_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (lane_req),
        .we        (lane_we),
        .addr      (lane_addr),
        .wdata     (lane_wdata),
        .gnt       (lane_gnt),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata)
    );

    product_ram #(
        .LOGDEPTH (LOGDEPTH)
    ) product_ram_inst (
        .clk       (clk),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

`default_nettype wire

/* hw/product_ram.sv */
`default_nettype none

// single-port product memory
// both lane regions live here, lane index in the top address bit
module product_ram #(
    parameter int LOGDEPTH = 6
) (
    input  logic                   clk,
    input  logic                   ram_en,
    input  logic                   ram_we,
    input  logic [LOGDEPTH:0]      ram_addr,
    input  prod_buf_pkg::product_t ram_wdata,
    output prod_buf_pkg::product_t ram_rdata
);
    import prod_buf_pkg::*;

    // two regions of 2^LOGDEPTH words
    localparam int DEPTH = 2 ** (LOGDEPTH + 1);

    product_t mem [DEPTH];

    // write on enabled write cycles, registered read otherwise
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* hw/mem_arbiter.sv */
`default_nettype none

// round-robin arbiter for the shared memory port
// one grant per cycle
// lane index forms the top address bit
module mem_arbiter #(
    parameter int LOGDEPTH = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             req,
    input  logic [1:0]             we,
    input  logic [LOGDEPTH-1:0]    addr [2],
    input  prod_buf_pkg::product_t wdata [2],
    output logic [1:0]             gnt,
    output logic                   ram_en,
    output logic                   ram_we,
    output logic [LOGDEPTH:0]      ram_addr,
    output prod_buf_pkg::product_t ram_wdata
);

    // lane favoured on the next tie
    // starts at lane 0
    logic rr_ptr;
    // winning lane
    logic sel;

    always_comb begin
        if (req == 2'b11) begin
            gnt = rr_ptr ? 2'b10 : 2'b01;
        end else begin
            gnt = req;
        end
    end

    assign sel = gnt[1];

    // winner's fields to the ram
    assign ram_en    = |gnt;
    assign ram_we    = ram_en && we[sel];
    assign ram_addr  = {sel, addr[sel]};
    assign ram_wdata = wdata[sel];

    // next tie goes to the lane not granted last
    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= 1'b0;
        end else if (ram_en) begin
            rr_ptr <= !sel;
        end
    end

    // back-to-back ties never go to the same lane twice
    a_tie_alternates: assert property (
        @(posedge clk) disable iff (rst)
        (req == 2'b11 && $past(req) == 2'b11) |-> gnt != $past(gnt)
    );

endmodule

`default_nettype wire

/* hw/mult_lane.sv */
`default_nettype none

// one multiplier lane
// fills its memory region with products and streams it back on request
module mult_lane #(
    parameter int LOGDEPTH = 6
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mult_en,
    input  prod_buf_pkg::operand_t op_a,
    input  prod_buf_pkg::operand_t op_b,
    output logic                   mult_rdy,
    input  logic                   block_read,
    output logic                   block_full,
    output logic                   rd_valid,
    output prod_buf_pkg::product_t rd_data,
    output logic                   mem_req,
    output logic                   mem_we,
    output logic [LOGDEPTH-1:0]    mem_addr,
    output prod_buf_pkg::product_t mem_wdata,
    input  logic                   mem_gnt,
    input  prod_buf_pkg::product_t mem_rdata
);
    import prod_buf_pkg::*;

    lane_state_t state;

    // operand register as the first stage
    operand_t op_a_q;
    operand_t op_b_q;
    logic     op_valid;

    // pending product slot waiting for the memory
    product_t pend_data;
    logic     pend_valid;

    // pairs accepted in this block
    // top bit set once the block is complete
    logic [LOGDEPTH:0] acc_cnt;
    logic [LOGDEPTH-1:0] wr_addr;
    // reads issued in this block
    // top bit set once all are granted
    logic [LOGDEPTH:0] rd_cnt;

    logic accept;
    logic pend_free;
    logic op_adv;
    logic wr_gnt;
    logic rd_req;
    logic rd_gnt;
    logic last_wr;
    logic last_rd;

    // slot frees up when empty or when its write is granted this cycle
    assign wr_gnt    = mem_gnt && pend_valid;
    assign pend_free = !pend_valid || wr_gnt;
    assign op_adv    = op_valid && pend_free;

    // ready only while filling with room downstream and the block not complete
    assign mult_rdy = (state == LANE_IDLE || state == LANE_FILL) && pend_free
                      && !acc_cnt[LOGDEPTH];
    assign accept   = mult_en && mult_rdy;

    // one read request per word while draining
    assign rd_req = (state == LANE_DRAIN) && !rd_cnt[LOGDEPTH];
    assign rd_gnt = mem_gnt && rd_req;

    assign last_wr = wr_gnt && (wr_addr == '1);
    // last word shows up after every read was granted
    assign last_rd = rd_valid && rd_cnt[LOGDEPTH];

    // memory request
    // a pending write and a read never overlap
    assign mem_req   = pend_valid || rd_req;
    assign mem_we    = pend_valid;
    assign mem_addr  = pend_valid ? wr_addr : rd_cnt[LOGDEPTH-1:0];
    assign mem_wdata = pend_data;

    assign block_full = (state == LANE_FULL);
    // read data is broadcast
    // rd_valid tags our own word
    assign rd_data    = mem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LANE_IDLE;
        end else begin
            case (state)
                LANE_IDLE: begin
                    if (accept) begin
                        state <= LANE_FILL;
                    end
                end
                LANE_FILL: begin
                    if (last_wr) begin
                        state <= LANE_FULL;
                    end
                end
                // block_read outside full is ignored
                LANE_FULL: begin
                    if (block_read) begin
                        state <= LANE_DRAIN;
                    end
                end
                LANE_DRAIN: begin
                    if (last_rd) begin
                        state <= LANE_IDLE;
                    end
                end
                default: state <= LANE_IDLE;
            endcase
        end
    end

    // operand register
    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (accept) begin
            op_valid <= 1'b1;
        end else if (op_adv) begin
            op_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_a_q <= op_a;
            op_b_q <= op_b;
        end
    end

    // multiply into the pending slot
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else if (op_adv) begin
            pend_valid <= 1'b1;
        end else if (wr_gnt) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_adv) begin
            pend_data <= product_t'(op_a_q) * product_t'(op_b_q);
        end
    end

    // counters
    always_ff @(posedge clk) begin
        if (rst || state == LANE_FULL) begin
            acc_cnt <= '0;
        end else if (accept) begin
            acc_cnt <= acc_cnt + 1'b1;
        end
    end

    // wraps back to zero after the last write of the block
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr <= '0;
        end else if (wr_gnt) begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || last_rd) begin
            rd_cnt <= '0;
        end else if (rd_gnt) begin
            rd_cnt <= rd_cnt + 1'b1;
        end
    end

    // ram returns data one cycle after the granted read
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_gnt;
        end
    end

    // no write may leak into the drain phase
    a_no_write_in_drain: assert property (
        @(posedge clk) disable iff (rst)
        state == LANE_DRAIN |-> !mem_we
    );

    // a full block has nothing in flight and every address was written
    a_full_block_settled: assert property (
        @(posedge clk) disable iff (rst)
        state == LANE_FULL |-> !op_valid && !pend_valid && wr_addr == '0
    );

    // valid words only come back while this lane drains
    a_valid_in_drain: assert property (
        @(posedge clk) disable iff (rst)
        rd_valid |-> state == LANE_DRAIN
    );

endmodule

`default_nettype wire

/* hw/prod_buf_pkg.sv */
`default_nettype none

// shared types for the two-lane product buffer
package prod_buf_pkg;

    // operand and product widths
    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 2 * OPERAND_W;

    // one multiplier input
    typedef logic [OPERAND_W-1:0] operand_t;

    // one product, also one memory word
    typedef logic [PRODUCT_W-1:0] product_t;

    // lane sequencing
    // idle    nothing stored, waiting for the first pair
    // fill    products going into the lane region
    // full    whole block stored, waiting for block_read
    // drain   block streaming back out
    typedef enum logic [1:0] {
        LANE_IDLE  = 2'b00,
        LANE_FILL  = 2'b01,
        LANE_FULL  = 2'b10,
        LANE_DRAIN = 2'b11
    } lane_state_t;

endpackage

`default_nettype wire
